// File: filelist.f
+incdir+include
src/uart_irq_pkg.sv
src/uart_rx_fifo.sv
src/uart_status_regs.sv
src/uart_reg_if.sv
src/uart_interrupts.sv
src/uart_irq_top.sv
verification/uart_irq_props.sv
verification/uart_irq_tb.sv

// File: include/uart_irq_settings.svh
`ifndef UART_IRQ_SETTINGS_SVH
`define UART_IRQ_SETTINGS_SVH

// Receive FIFO entries
`define UART_IRQ_FIFO_DEPTH 16

// Read and write pointer width, log2 of the depth
`define UART_IRQ_FIFO_PTR_W 4

// Idle clocks with data waiting before a character timeout
`define UART_IRQ_TIMEOUT_CYCLES 32

`endif

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; exit status carries pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module uart_irq_tb \
  -f filelist.f -o uart_irq_sim &&
./obj_dir/uart_irq_sim ||
{ echo "simulation failed"; exit 1; }

// File: src/uart_interrupts.sv
`timescale 1ns/1ps
`default_nettype none

module uart_interrupts (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                rx_fifo_trigger_i,
  input  wire logic                rx_timeout_i,
  input  wire logic                data_ready_i,
  input  wire logic [3:0]          lsr_errs_i,
  input  wire uart_irq_pkg::byte_t msr_i,
  input  wire logic                thr_empty_i,
  input  wire uart_irq_pkg::ier_t  ier_i,
  input  wire uart_irq_pkg::fcr_t  fcr_i,
  input  wire logic                rhr_read_i,
  input  wire logic                lsr_read_i,
  input  wire logic                msr_read_i,
  input  wire logic                thr_write_i,
  output uart_irq_pkg::isr_t       isr_o,
  output logic                     irq_o
);
  import uart_irq_pkg::*;

  logic       fifo_en;
  logic       rls_src;
  logic       rxdr_src;
  logic       tmo_src;
  logic       thre_src;
  logic       mst_src;
  logic       rxdr_clr;
  logic       rls_q;
  logic       rxdr_q;
  logic       tmo_q;
  logic       thre_q;
  logic       mst_q;
  irq_state_e state;
  irq_id_t    irq_id;

  assign fifo_en = fcr_i[0];

  //////////////////////////////////////////////////////////////////////
  // Enabled sources
  //////////////////////////////////////////////////////////////////////

  assign rls_src  = ier_i[2] & (|lsr_errs_i);
  // Trigger level in FIFO mode, single byte otherwise
  assign rxdr_src = ier_i[0] & (fifo_en ? rx_fifo_trigger_i : data_ready_i);
  // Timeout only exists with the FIFO on
  assign tmo_src  = ier_i[0] & fifo_en & rx_timeout_i;
  assign thre_src = ier_i[1] & thr_empty_i;
  // Any of the four deltas
  assign mst_src  = ier_i[3] & (|msr_i[3:0]);

  // In FIFO mode, the read must find the level already below trigger
  assign rxdr_clr = rhr_read_i & (~fifo_en | ~rx_fifo_trigger_i);

  //////////////////////////////////////////////////////////////////////
  // Cause latches
  //////////////////////////////////////////////////////////////////////

  // Clear wins over a source still high in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rls_q  <= 1'b0;
      rxdr_q <= 1'b0;
      tmo_q  <= 1'b0;
      thre_q <= 1'b0;
      mst_q  <= 1'b0;
    end else begin
      rls_q  <= (rls_src | rls_q) & ~lsr_read_i;
      rxdr_q <= (rxdr_src | rxdr_q) & ~rxdr_clr;
      tmo_q  <= (tmo_src | tmo_q) & ~rhr_read_i;
      thre_q <= (thre_src | thre_q) & ~thr_write_i;
      mst_q  <= (mst_src | mst_q) & ~msr_read_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Priority encoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (rls_q) begin
      state = IRQ_RLS;
    end else if (rxdr_q) begin
      state = IRQ_RXDR;
    end else if (tmo_q) begin
      state = IRQ_TIMEOUT;
    end else if (thre_q) begin
      state = IRQ_THRE;
    end else if (mst_q) begin
      state = IRQ_MSTAT;
    end else begin
      state = IRQ_NONE;
    end
  end

  // 16550 id codes; modem status and idle share zero
  always_comb begin
    case (state)
      IRQ_RLS:     irq_id = 3'd3;
      IRQ_RXDR:    irq_id = 3'd2;
      IRQ_TIMEOUT: irq_id = 3'd6;
      IRQ_THRE:    irq_id = 3'd1;
      default:     irq_id = 3'd0;
    endcase
  end

  // Line stays high until every latched cause is served
  assign irq_o = rls_q | rxdr_q | tmo_q | thre_q | mst_q;
  // FIFOs present, status bit active low
  assign isr_o = {2'b11, 2'b00, irq_id, (state == IRQ_NONE)};

endmodule

`default_nettype wire

// File: src/uart_irq_pkg.sv
`default_nettype none

package uart_irq_pkg;

  // Register offset on the CPU port
  // 0 RHR/THR, 1 IER, 2 ISR/FCR, 5 LSR, 6 MSR
  typedef logic [2:0] reg_addr_t;

  // Character and register data
  typedef logic [7:0] byte_t;

  // Interrupt enables
  // [0] data ready and timeout, [1] THR empty
  // [2] receive line status, [3] modem status
  typedef logic [3:0] ier_t;

  // FIFO control
  // [0] FIFO enable, [1] receive FIFO reset (self clearing)
  // [7:6] trigger code, 1/4/8/14 entries
  typedef logic [7:0] fcr_t;

  // Interrupt identification code, ISR bits 3:1
  typedef logic [2:0] irq_id_t;

  // ISR layout
  // [0] low while pending, [3:1] id, [5:4] zero, [7:6] FIFOs present
  typedef logic [7:0] isr_t;

  // Winning cause of the priority encoder
  typedef enum logic [2:0] {
    IRQ_NONE,
    IRQ_RLS,
    IRQ_RXDR,
    IRQ_TIMEOUT,
    IRQ_THRE,
    IRQ_MSTAT
  } irq_state_e;

endpackage

`default_nettype wire

// File: src/uart_irq_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_irq_top (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  // CPU register port
  input  wire uart_irq_pkg::reg_addr_t reg_addr_i,
  input  wire logic                    reg_wr_i,
  input  wire logic                    reg_rd_i,
  input  wire uart_irq_pkg::byte_t     reg_wdata_i,
  output uart_irq_pkg::byte_t          reg_rdata_o,
  // Decoded receive characters
  input  wire logic                    rx_valid_i,
  input  wire uart_irq_pkg::byte_t     rx_data_i,
  input  wire logic                    rx_par_err_i,
  input  wire logic                    rx_frame_err_i,
  input  wire logic                    rx_break_i,
  // Modem pins
  input  wire logic                    cts_i,
  input  wire logic                    dsr_i,
  input  wire logic                    ri_i,
  input  wire logic                    dcd_i,
  // Transmitter hand-off
  input  wire logic                    tx_take_i,
  output uart_irq_pkg::byte_t          tx_data_o,
  output logic                         irq_o
);
  import uart_irq_pkg::*;

  // Register port strobes and control
  ier_t       ier;
  fcr_t       fcr;
  logic       rhr_read;
  logic       lsr_read;
  logic       msr_read;
  logic       thr_write;
  logic       fifo_clear;
  // Receive FIFO
  byte_t      rx_head;
  logic       data_ready;
  logic       rx_fifo_trigger;
  logic       rx_timeout;
  logic       overrun;
  // Status
  logic [3:0] lsr_errs;
  logic       thr_empty;
  byte_t      msr;
  isr_t       isr;

  uart_reg_if UART_REG_IF (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wr_i     (reg_wr_i),
    .reg_rd_i     (reg_rd_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .rx_head_i    (rx_head),
    .lsr_errs_i   (lsr_errs),
    .data_ready_i (data_ready),
    .thr_empty_i  (thr_empty),
    .msr_i        (msr),
    .isr_i        (isr),
    .ier_o        (ier),
    .fcr_o        (fcr),
    .rhr_read_o   (rhr_read),
    .lsr_read_o   (lsr_read),
    .msr_read_o   (msr_read),
    .thr_write_o  (thr_write),
    .fifo_clear_o (fifo_clear)
  );

  uart_rx_fifo UART_RX_FIFO (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .rx_valid_i        (rx_valid_i),
    .rx_data_i         (rx_data_i),
    .fcr_i             (fcr),
    .rhr_read_i        (rhr_read),
    .fifo_clear_i      (fifo_clear),
    .rx_head_o         (rx_head),
    .data_ready_o      (data_ready),
    .rx_fifo_trigger_o (rx_fifo_trigger),
    .rx_timeout_o      (rx_timeout),
    .overrun_o         (overrun)
  );

  uart_status_regs UART_STATUS_REGS (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .rx_valid_i     (rx_valid_i),
    .rx_par_err_i   (rx_par_err_i),
    .rx_frame_err_i (rx_frame_err_i),
    .rx_break_i     (rx_break_i),
    .overrun_i      (overrun),
    .cts_i          (cts_i),
    .dsr_i          (dsr_i),
    .ri_i           (ri_i),
    .dcd_i          (dcd_i),
    .lsr_read_i     (lsr_read),
    .msr_read_i     (msr_read),
    .thr_write_i    (thr_write),
    .wdata_i        (reg_wdata_i),
    .tx_take_i      (tx_take_i),
    .lsr_errs_o     (lsr_errs),
    .msr_o          (msr),
    .thr_empty_o    (thr_empty),
    .tx_data_o      (tx_data_o)
  );

  uart_interrupts UART_INTERRUPTS (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .rx_fifo_trigger_i (rx_fifo_trigger),
    .rx_timeout_i      (rx_timeout),
    .data_ready_i      (data_ready),
    .lsr_errs_i        (lsr_errs),
    .msr_i             (msr),
    .thr_empty_i       (thr_empty),
    .ier_i             (ier),
    .fcr_i             (fcr),
    .rhr_read_i        (rhr_read),
    .lsr_read_i        (lsr_read),
    .msr_read_i        (msr_read),
    .thr_write_i       (thr_write),
    .isr_o             (isr),
    .irq_o             (irq_o)
  );

endmodule

`default_nettype wire

// File: src/uart_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

module uart_reg_if (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire uart_irq_pkg::reg_addr_t reg_addr_i,
  input  wire logic                    reg_wr_i,
  input  wire logic                    reg_rd_i,
  input  wire uart_irq_pkg::byte_t     reg_wdata_i,
  output uart_irq_pkg::byte_t          reg_rdata_o,
  input  wire uart_irq_pkg::byte_t     rx_head_i,
  input  wire logic [3:0]              lsr_errs_i,
  input  wire logic                    data_ready_i,
  input  wire logic                    thr_empty_i,
  input  wire uart_irq_pkg::byte_t     msr_i,
  input  wire uart_irq_pkg::isr_t      isr_i,
  output uart_irq_pkg::ier_t           ier_o,
  output uart_irq_pkg::fcr_t           fcr_o,
  output logic                         rhr_read_o,
  output logic                         lsr_read_o,
  output logic                         msr_read_o,
  output logic                         thr_write_o,
  output logic                         fifo_clear_o
);
  import uart_irq_pkg::*;

  ier_t  ier_q;
  fcr_t  fcr_q;
  byte_t lsr;
  logic  ier_wr;
  logic  fcr_wr;

  //////////////////////////////////////////////////////////////////////
  // Access decode
  //////////////////////////////////////////////////////////////////////

  // Offset 0 is THR on write, RHR on read
  assign thr_write_o = reg_wr_i & (reg_addr_i == 3'd0);
  // Empty RHR reads must not move the read pointer
  assign rhr_read_o  = reg_rd_i & (reg_addr_i == 3'd0) & data_ready_i;
  assign ier_wr      = reg_wr_i & (reg_addr_i == 3'd1);
  // Offset 2 is FCR on write, ISR on read
  assign fcr_wr      = reg_wr_i & (reg_addr_i == 3'd2);
  assign lsr_read_o  = reg_rd_i & (reg_addr_i == 3'd5);
  assign msr_read_o  = reg_rd_i & (reg_addr_i == 3'd6);

  // FIFO flush on explicit reset bit or mode switch
  assign fifo_clear_o = fcr_wr & (reg_wdata_i[1] | (reg_wdata_i[0] ^ fcr_q[0]));

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ier_q <= '0;
      fcr_q <= '0;
    end else begin
      if (ier_wr) begin
        ier_q <= reg_wdata_i[3:0];
      end
      // Bit 1 acts once, reserved bits read back zero
      if (fcr_wr) begin
        fcr_q <= {reg_wdata_i[7:6], 5'b00000, reg_wdata_i[0]};
      end
    end
  end

  assign ier_o = ier_q;
  assign fcr_o = fcr_q;

  //////////////////////////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////////////////////////

  // LSR assembly
  // [7] any receive error, [6] transmitter idle, [5] THR empty
  // [4:1] break, framing, parity, overrun, [0] data ready
  // No shifter here, so transmitter idle follows THR empty
  assign lsr = {|lsr_errs_i, thr_empty_i, thr_empty_i,
                lsr_errs_i[3], lsr_errs_i[2], lsr_errs_i[1], lsr_errs_i[0],
                data_ready_i};

  always_comb begin
    case (reg_addr_i)
      3'd0:    reg_rdata_o = data_ready_i ? rx_head_i : 8'h00;
      3'd1:    reg_rdata_o = {4'b0000, ier_q};
      3'd2:    reg_rdata_o = isr_i;
      3'd5:    reg_rdata_o = lsr;
      3'd6:    reg_rdata_o = msr_i;
      default: reg_rdata_o = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

// File: src/uart_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_irq_settings.svh"

module uart_rx_fifo (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                rx_valid_i,
  input  wire uart_irq_pkg::byte_t rx_data_i,
  input  wire uart_irq_pkg::fcr_t  fcr_i,
  input  wire logic                rhr_read_i,
  input  wire logic                fifo_clear_i,
  output uart_irq_pkg::byte_t      rx_head_o,
  output logic                     data_ready_o,
  output logic                     rx_fifo_trigger_o,
  output logic                     rx_timeout_o,
  output logic                     overrun_o
);
  import uart_irq_pkg::*;

  localparam int unsigned PTR_W = `UART_IRQ_FIFO_PTR_W;
  localparam int unsigned TO_W  = $clog2(`UART_IRQ_TIMEOUT_CYCLES + 1);

  // Fill count needs one extra bit to hold the full depth
  typedef logic [PTR_W:0]   cnt_t;
  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [TO_W-1:0]  idle_t;

  localparam cnt_t  DEPTH  = cnt_t'(`UART_IRQ_FIFO_DEPTH);
  localparam idle_t TO_MAX = idle_t'(`UART_IRQ_TIMEOUT_CYCLES);

  byte_t mem [`UART_IRQ_FIFO_DEPTH];
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  cnt_t  fill_cnt;
  idle_t idle_cnt;
  cnt_t  trig_lvl;
  logic  full;
  logic  push;
  logic  pop;

  //////////////////////////////////////////////////////////////////////
  // Fill state
  //////////////////////////////////////////////////////////////////////

  // Non-FIFO mode behaves as a single holding byte
  assign full = fcr_i[0] ? (fill_cnt >= DEPTH) : (fill_cnt != '0);

  // Character on a full FIFO is dropped and flagged
  assign push      = rx_valid_i & ~full;
  assign overrun_o = rx_valid_i & full;
  // Register port only strobes a read while data is waiting
  assign pop       = rhr_read_i;

  always_comb begin
    case (fcr_i[7:6])
      2'd0:    trig_lvl = cnt_t'(1);
      2'd1:    trig_lvl = cnt_t'(4);
      2'd2:    trig_lvl = cnt_t'(8);
      default: trig_lvl = cnt_t'(14);
    endcase
  end

  assign rx_head_o         = mem[rd_ptr];
  assign data_ready_o      = (fill_cnt != '0);
  assign rx_fifo_trigger_o = (fill_cnt >= trig_lvl);

  always_ff @(posedge clk_i) begin
    if (reset_i || fifo_clear_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        fill_cnt <= fill_cnt + 1'b1;
      end else if (pop && !push) begin
        fill_cnt <= fill_cnt - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= rx_data_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Character timeout
  //////////////////////////////////////////////////////////////////////

  // Restart on any traffic, saturate at the limit
  always_ff @(posedge clk_i) begin
    if (reset_i || fifo_clear_i || push || pop || !data_ready_o) begin
      idle_cnt <= '0;
    end else if (idle_cnt != TO_MAX) begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  assign rx_timeout_o = (idle_cnt == TO_MAX) & data_ready_o;

endmodule

`default_nettype wire

// File: src/uart_status_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_status_regs (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                rx_valid_i,
  input  wire logic                rx_par_err_i,
  input  wire logic                rx_frame_err_i,
  input  wire logic                rx_break_i,
  input  wire logic                overrun_i,
  input  wire logic                cts_i,
  input  wire logic                dsr_i,
  input  wire logic                ri_i,
  input  wire logic                dcd_i,
  input  wire logic                lsr_read_i,
  input  wire logic                msr_read_i,
  input  wire logic                thr_write_i,
  input  wire uart_irq_pkg::byte_t wdata_i,
  input  wire logic                tx_take_i,
  output logic [3:0]               lsr_errs_o,
  output uart_irq_pkg::byte_t      msr_o,
  output logic                     thr_empty_o,
  output uart_irq_pkg::byte_t      tx_data_o
);
  import uart_irq_pkg::*;

  logic [3:0] err_new;
  logic [3:0] err_q;
  logic [3:0] modem_now;
  logic [3:0] modem_q;
  logic [3:0] delta_now;
  logic [3:0] delta_q;
  logic       thr_empty_q;
  byte_t      thr_q;

  //////////////////////////////////////////////////////////////////////
  // Line status errors
  //////////////////////////////////////////////////////////////////////

  // Order {break, framing, parity, overrun}
  assign err_new = {rx_break_i & rx_valid_i,
                    rx_frame_err_i & rx_valid_i,
                    rx_par_err_i & rx_valid_i,
                    overrun_i};

  // A new error in the read cycle survives the read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q <= '0;
    end else begin
      err_q <= (lsr_read_i ? 4'b0000 : err_q) | err_new;
    end
  end

  assign lsr_errs_o = err_q;

  //////////////////////////////////////////////////////////////////////
  // Modem inputs
  //////////////////////////////////////////////////////////////////////

  // Order {DCD, RI, DSR, CTS}, same as MSR bits 7:4
  assign modem_now = {dcd_i, ri_i, dsr_i, cts_i};

  // RI only counts its trailing edge
  assign delta_now = {modem_now[3] ^ modem_q[3],
                      modem_q[2] & ~modem_now[2],
                      modem_now[1] ^ modem_q[1],
                      modem_now[0] ^ modem_q[0]};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Track the pins so release from reset shows no delta
      modem_q <= modem_now;
      delta_q <= '0;
    end else begin
      modem_q <= modem_now;
      delta_q <= (msr_read_i ? 4'b0000 : delta_q) | delta_now;
    end
  end

  assign msr_o = {modem_q, delta_q};

  //////////////////////////////////////////////////////////////////////
  // Transmit holding register
  //////////////////////////////////////////////////////////////////////

  // Write in the take cycle refills the holding byte
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      thr_empty_q <= 1'b1;
    end else if (thr_write_i) begin
      thr_empty_q <= 1'b0;
    end else if (tx_take_i) begin
      thr_empty_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (thr_write_i) begin
      thr_q <= wdata_i;
    end
  end

  assign thr_empty_o = thr_empty_q;
  assign tx_data_o   = thr_q;

endmodule

`default_nettype wire

// File: verification/uart_irq_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_irq_settings.svh"

module uart_irq_props (
  input wire logic                           clk_i,
  input wire logic                           reset_i,
  input wire uart_irq_pkg::ier_t             ier_i,
  input wire uart_irq_pkg::isr_t             isr_i,
  input wire uart_irq_pkg::irq_state_e       state_i,
  input wire logic                           irq_i,
  input wire logic [`UART_IRQ_FIFO_PTR_W:0]  fill_cnt_i
);
  import uart_irq_pkg::*;

  localparam int unsigned DEPTH = `UART_IRQ_FIFO_DEPTH;

  //////////////////////////////////////////////////////////////////////
  // Interrupt line
  //////////////////////////////////////////////////////////////////////

  // No enabled cause, no winner and no line
  a_quiet_without_ier : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (ier_i == '0) |-> (state_i == IRQ_NONE && !irq_i)
  ) else $error("irq_o or a latched cause with all enables off");

  // ISR status bit is active low
  a_isr_status : assert property (
    @(posedge clk_i) disable iff (reset_i)
    irq_i == ~isr_i[0]
  ) else $error("ISR bit 0 disagrees with irq_o");

  //////////////////////////////////////////////////////////////////////
  // Receive FIFO
  //////////////////////////////////////////////////////////////////////

  a_fifo_bound : assert property (
    @(posedge clk_i) disable iff (reset_i)
    fill_cnt_i <= DEPTH[`UART_IRQ_FIFO_PTR_W:0]
  ) else $error("receive FIFO count beyond its depth");

endmodule

bind uart_irq_top uart_irq_props PROPS (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .ier_i      (ier),
  .isr_i      (isr),
  .state_i    (UART_INTERRUPTS.state),
  .irq_i      (irq_o),
  .fill_cnt_i (UART_RX_FIFO.fill_cnt)
);

`default_nettype wire

// File: verification/uart_irq_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_irq_settings.svh"

module uart_irq_tb;
  import uart_irq_pkg::*;

  typedef enum int {
    STEP_WR,
    STEP_RD,
    STEP_RX,
    STEP_RX_PE,
    STEP_MODEM,
    STEP_TAKE,
    STEP_IDLE
  } step_kind_e;

  // Timeout wait with some slack past the counter limit
  localparam int IDLE_LIMIT = `UART_IRQ_TIMEOUT_CYCLES + 8;

  logic      clk_i;
  logic      reset_i;
  reg_addr_t reg_addr_i;
  logic      reg_wr_i;
  logic      reg_rd_i;
  byte_t     reg_wdata_i;
  byte_t     reg_rdata_o;
  logic      rx_valid_i;
  byte_t     rx_data_i;
  logic      rx_par_err_i;
  logic      rx_frame_err_i;
  logic      rx_break_i;
  logic      cts_i;
  logic      dsr_i;
  logic      ri_i;
  logic      dcd_i;
  logic      tx_take_i;
  byte_t     tx_data_o;
  logic      irq_o;

  // Stimulus table, one entry per step
  step_kind_e kind_q[$];
  int         addr_q[$];
  int         data_q[$];
  int         mask_q[$];
  int         exp_q[$];
  int         count_q[$];
  logic       irq_q[$];
  string      name_q[$];

  // Reference model of the receive FIFO and holding byte
  byte_t rx_model[$];
  byte_t thr_model;
  logic  fifo_en_model;

  uart_irq_top UUT (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wr_i       (reg_wr_i),
    .reg_rd_i       (reg_rd_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_rdata_o    (reg_rdata_o),
    .rx_valid_i     (rx_valid_i),
    .rx_data_i      (rx_data_i),
    .rx_par_err_i   (rx_par_err_i),
    .rx_frame_err_i (rx_frame_err_i),
    .rx_break_i     (rx_break_i),
    .cts_i          (cts_i),
    .dsr_i          (dsr_i),
    .ri_i           (ri_i),
    .dcd_i          (dcd_i),
    .tx_take_i      (tx_take_i),
    .tx_data_o      (tx_data_o),
    .irq_o          (irq_o)
  );

  // 8 ns clock
  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////////////////////////

  task automatic add_step(input step_kind_e kind, input int addr, input int data,
                          input int mask, input int exp, input int count,
                          input logic irq, input string name);
    kind_q.push_back(kind);
    addr_q.push_back(addr);
    data_q.push_back(data);
    mask_q.push_back(mask);
    exp_q.push_back(exp);
    count_q.push_back(count);
    irq_q.push_back(irq);
    name_q.push_back(name);
  endtask

  // ISR ids: C1 idle, C2 THR empty, C4 data ready, CC timeout
  // C6 line status, C0 modem status
  task automatic build_table();
    // THR empty cause and transmitter hand-off
    add_step(STEP_RD,    2, 0,     'hFF, 'hC1, 1, 1'b0, "isr_after_reset");
    add_step(STEP_WR,    1, 'h02,  0,    0,    1, 1'b1, "ier_thre");
    add_step(STEP_RD,    2, 0,     'hFF, 'hC2, 1, 1'b1, "isr_thre");
    add_step(STEP_WR,    0, 'hA5,  0,    0,    1, 1'b0, "thr_write");
    add_step(STEP_TAKE,  0, 0,     0,    0,    1, 1'b1, "tx_take");
    add_step(STEP_WR,    0, 'h3C,  0,    0,    1, 1'b0, "thr_refill");
    add_step(STEP_WR,    1, 'h00,  0,    0,    1, 1'b0, "ier_off");
    // Trigger level 4
    add_step(STEP_WR,    2, 'h41,  0,    0,    1, 1'b0, "fcr_trig4");
    add_step(STEP_WR,    1, 'h01,  0,    0,    1, 1'b0, "ier_rx");
    add_step(STEP_RX,    0, 0,     0,    0,    3, 1'b0, "rx_three");
    add_step(STEP_RX,    0, 0,     0,    0,    1, 1'b1, "rx_fourth");
    add_step(STEP_RD,    2, 0,     'hFF, 'hC4, 1, 1'b1, "isr_rx_ready");
    add_step(STEP_RD,    0, 0,     'hFF, 0,    4, 1'b0, "rhr_four");
    // Character timeout below the trigger
    add_step(STEP_RX,    0, 0,     0,    0,    2, 1'b0, "rx_two");
    add_step(STEP_IDLE,  0, 0,     0,    0,    IDLE_LIMIT, 1'b1, "char_timeout");
    add_step(STEP_RD,    2, 0,     'hFF, 'hCC, 1, 1'b1, "isr_timeout");
    add_step(STEP_RD,    0, 0,     'hFF, 0,    1, 1'b0, "rhr_clears_timeout");
    add_step(STEP_RD,    0, 0,     'hFF, 0,    1, 1'b0, "rhr_drain_two");
    // Line status over data ready, single byte mode
    add_step(STEP_WR,    2, 'h00,  0,    0,    1, 1'b0, "fifo_off");
    add_step(STEP_WR,    1, 'h05,  0,    0,    1, 1'b0, "ier_rls_rx");
    add_step(STEP_RX_PE, 0, 0,     0,    0,    1, 1'b1, "rx_parity");
    add_step(STEP_RD,    2, 0,     'hFF, 'hC6, 1, 1'b1, "isr_rls");
    add_step(STEP_RD,    5, 0,     'h04, 'h04, 1, 1'b1, "lsr_parity");
    add_step(STEP_RD,    2, 0,     'hFF, 'hC4, 1, 1'b1, "isr_after_lsr");
    add_step(STEP_RD,    0, 0,     'hFF, 0,    1, 1'b0, "rhr_parity_char");
    // Overrun, one character past the depth
    add_step(STEP_WR,    1, 'h00,  0,    0,    1, 1'b0, "ier_off_again");
    add_step(STEP_WR,    2, 'hC1,  0,    0,    1, 1'b0, "fcr_trig14");
    add_step(STEP_RX,    0, 0,     0,    0,    `UART_IRQ_FIFO_DEPTH + 1, 1'b0, "rx_overfill");
    add_step(STEP_RD,    5, 0,     'h03, 'h03, 1, 1'b0, "lsr_overrun");
    add_step(STEP_RD,    0, 0,     'hFF, 0,    `UART_IRQ_FIFO_DEPTH, 1'b0, "rhr_drain_full");
    // Modem status from a CTS change
    add_step(STEP_WR,    1, 'h08,  0,    0,    1, 1'b0, "ier_modem");
    add_step(STEP_MODEM, 0, 'h01,  0,    0,    1, 1'b1, "cts_change");
    add_step(STEP_RD,    2, 0,     'hFF, 'hC0, 1, 1'b1, "isr_modem");
    add_step(STEP_RD,    6, 0,     'h11, 'h11, 1, 1'b0, "msr_delta_cts");
    add_step(STEP_RD,    2, 0,     'hFF, 'hC1, 1, 1'b0, "isr_idle");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("CHECK FAILED %s expected 0x%02h actual 0x%02h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first failing check");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Step execution
  //////////////////////////////////////////////////////////////////////

  // Starts and ends on a falling edge
  task automatic run_step(input int idx);
    step_kind_e kind;
    int         addr;
    int         data;
    int         mask;
    int         expect_rd;
    int         depth;
    int         rep;
    int         cycles;
    byte_t      rnd_byte;
    string      name;

    kind = kind_q[idx];
    addr = addr_q[idx];
    data = data_q[idx];
    name = name_q[idx];

    if (kind == STEP_IDLE) begin
      // Bounded wait for the expected line level
      cycles = 0;
      while (irq_o !== irq_q[idx] && cycles < count_q[idx]) begin
        @(posedge clk_i);
        @(negedge clk_i);
        cycles++;
      end
      assert (irq_o === irq_q[idx]) else begin
        $display("Timed out after %0d cycles waiting for irq_o in step %s", cycles, name);
        $display("ERRORS FOUND");
        $fatal(1, "irq_o never reached its expected level");
      end
    end else begin
      for (rep = 0; rep < count_q[idx]; rep++) begin
        expect_rd = 0;
        mask      = 'hFF;
        @(posedge clk_i);
        case (kind)
          STEP_WR: begin
            reg_addr_i  <= reg_addr_t'(addr);
            reg_wdata_i <= byte_t'(data);
            reg_wr_i    <= 1'b1;
            if (addr == 0) begin
              thr_model = byte_t'(data);
            end else if (addr == 2) begin
              // Reset bit or a mode switch flushes the FIFO
              if (data[1] || (data[0] != fifo_en_model)) begin
                rx_model.delete();
              end
              fifo_en_model = data[0];
            end
          end
          STEP_RD: begin
            reg_addr_i <= reg_addr_t'(addr);
            reg_rd_i   <= 1'b1;
            if (addr == 0) begin
              // Empty RHR reads back zero
              if (rx_model.size() > 0) begin
                expect_rd = rx_model.pop_front();
              end
            end else begin
              expect_rd = exp_q[idx];
              mask      = mask_q[idx];
            end
          end
          STEP_RX, STEP_RX_PE: begin
            rnd_byte     = byte_t'($urandom);
            rx_data_i    <= rnd_byte;
            rx_valid_i   <= 1'b1;
            rx_par_err_i <= (kind == STEP_RX_PE);
            // Single byte holding register with the FIFO off
            depth = fifo_en_model ? `UART_IRQ_FIFO_DEPTH : 1;
            if (rx_model.size() < depth) begin
              rx_model.push_back(rnd_byte);
            end
          end
          STEP_MODEM: begin
            {dcd_i, ri_i, dsr_i, cts_i} <= data[3:0];
          end
          STEP_TAKE: begin
            tx_take_i <= 1'b1;
          end
          default: begin
          end
        endcase

        // Read data and holding byte settle before the access edge
        @(negedge clk_i);
        if (kind == STEP_RD) begin
          check_value($sformatf("%s[%0d]", name, rep), expect_rd & mask,
                      int'(reg_rdata_o) & mask);
        end else if (kind == STEP_TAKE) begin
          check_value(name, thr_model, tx_data_o);
        end

        @(posedge clk_i);
        reg_wr_i     <= 1'b0;
        reg_rd_i     <= 1'b0;
        rx_valid_i   <= 1'b0;
        rx_par_err_i <= 1'b0;
        tx_take_i    <= 1'b0;
        // One more edge for the cause latches
        @(posedge clk_i);
        @(negedge clk_i);
      end
      check_value({name, " irq"}, irq_q[idx], irq_o);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int i;

    void'($urandom(16));
    reset_i        = 1'b1;
    reg_addr_i     = '0;
    reg_wr_i       = 1'b0;
    reg_rd_i       = 1'b0;
    reg_wdata_i    = '0;
    rx_valid_i     = 1'b0;
    rx_data_i      = '0;
    rx_par_err_i   = 1'b0;
    rx_frame_err_i = 1'b0;
    rx_break_i     = 1'b0;
    cts_i          = 1'b0;
    dsr_i          = 1'b0;
    ri_i           = 1'b0;
    dcd_i          = 1'b0;
    tx_take_i      = 1'b0;
    thr_model      = '0;
    fifo_en_model  = 1'b0;
    build_table();

    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);

    for (i = 0; i < kind_q.size(); i++) begin
      run_step(i);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
